//--- all.f
+incdir+include
src/nn_out_pkg.sv
src/delta_mem_if.sv
src/delta_mem_ctrl.sv
src/delta_mem_banks.sv
src/ideal_out_delay.sv
src/output_cost_unit.sv
src/output_layer_top.sv
dv/output_layer_tb.sv

//--- include/output_layer_ref.svh
// Output layer reference model for the cost term, the delta and the threshold
`ifndef OUTPUT_LAYER_REF_SVH
`define OUTPUT_LAYER_REF_SVH

// a - y with the ideal bit scaled to 1.0, wraps at WIDTH bits
function automatic nn_out_pkg::fix_t ref_cost_term(input nn_out_pkg::fix_t a,
		input logic y);
	nn_out_pkg::fix_t y_fix;
	y_fix = y ? nn_out_pkg::ONE_FIX : '0;
	return a - y_fix;
endfunction

// Delta per cost kind, product realigned and truncated
function automatic nn_out_pkg::fix_t ref_delta(input nn_out_pkg::fix_t a,
		input nn_out_pkg::fix_t sp, input logic y, input nn_out_pkg::cost_e cost);
	nn_out_pkg::fix_t                          c;
	logic signed [2*nn_out_pkg::WIDTH-1:0] prod;
	c = ref_cost_term(a, y);
	if (cost == nn_out_pkg::COST_XENT) begin
		return c;
	end
	prod = c * sp;
	prod = prod >>> nn_out_pkg::FRAC_BITS;
	return prod[nn_out_pkg::WIDTH-1:0];
endfunction

// 1 when the activation is at least one half
function automatic logic ref_decision(input nn_out_pkg::fix_t a);
	return (a >= nn_out_pkg::HALF_FIX);
endfunction

`endif

//--- dv/output_layer_tb.sv
// Output layer testbench with random and directed groups, reference model and scoreboards
`timescale 1ns/1ps
`default_nettype none

module output_layer_tb;

	`include "output_layer_ref.svh"

	localparam int HALF_PERIOD = 10;  // 20 ns clock
	localparam int STIM_DLY    = 2;   // Inputs change after the edge
	localparam int RST_CYCLES  = 8;
	localparam int N_QUAD      = 20;  // Samples under quadratic cost
	localparam int N_SAMPLES   = 40;  // Followed by one flush sample
	localparam int MAX_CYCLES  = N_SAMPLES * nn_out_pkg::CPC + nn_out_pkg::Y_DELAY
		+ RST_CYCLES + 140;

	localparam int ONE  = nn_out_pkg::ONE_FIX;
	localparam int HALF = nn_out_pkg::HALF_FIX;

	// DUT signals
	logic                   clk;
	logic                   arst_n_i;
	nn_out_pkg::cycle_idx_t cycle_index_i;
	nn_out_pkg::cost_e      cost_sel_i;
	nn_out_pkg::fix_vec_t   act_l_i;
	nn_out_pkg::fix_vec_t   sp_l_i;
	nn_out_pkg::bit_vec_t   y_i;
	nn_out_pkg::fix_vec_t   delta_l_o;
	nn_out_pkg::bit_vec_t   y_l_o;
	nn_out_pkg::bit_vec_t   a_out_o;

	// Bookkeeping
	integer seed;
	int     value_errs;
	int     idle_errs;
	int     cycle_cnt;
	int     cur_sample;   // Sample the driven group belongs to
	logic   run_checks;

	// Scoreboard models
	nn_out_pkg::bit_vec_t y_pipe [$];                            // Ideal output delay line
	nn_out_pkg::fix_vec_t bank_m [2][nn_out_pkg::GROUPS];        // Ping-pong delta banks
	logic                 wr_bank_m;
	nn_out_pkg::fix_vec_t delta_exp;                             // Expected registered read

	output_layer_top dut_i (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.cycle_index_i (cycle_index_i),
		.cost_sel_i    (cost_sel_i),
		.act_l_i       (act_l_i),
		.sp_l_i        (sp_l_i),
		.y_i           (y_i),
		.delta_l_o     (delta_l_o),
		.y_l_o         (y_l_o),
		.a_out_o       (a_out_o)
	);

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	// Uniform draw from 0 to n-1
	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	task automatic check_fix_vec(input string name, input nn_out_pkg::fix_vec_t got,
			input nn_out_pkg::fix_vec_t exp);
		if (got !== exp) begin
			value_errs++;
			$display("FAILED %s got %h expected %h, sample %0d index %0d", name, got, exp,
				cur_sample, cycle_index_i);
		end
	endtask

	task automatic check_bit_vec(input string name, input nn_out_pkg::bit_vec_t got,
			input nn_out_pkg::bit_vec_t exp);
		if (got !== exp) begin
			value_errs++;
			$display("FAILED %s got %h expected %h, sample %0d index %0d", name, got, exp,
				cur_sample, cycle_index_i);
		end
	endtask

	// Registered outputs must still read zero
	task automatic check_idle(input string when, input logic with_y);
		if (delta_l_o !== '0) begin
			idle_errs++;
			$display("Delta output is not zero %s, index %0d", when, cycle_index_i);
		end
		if (with_y && y_l_o !== '0) begin
			idle_errs++;
			$display("Delayed ideal output is not zero %s", when);
		end
	endtask

	// One group of inputs, random with a few directed lanes
	task automatic drive_group(input int s, input int k);
		nn_out_pkg::fix_vec_t act;
		nn_out_pkg::fix_vec_t sp;
		nn_out_pkg::bit_vec_t y;
		for (int i = 0; i < nn_out_pkg::Z; i++) begin
			if (s % 2 == 0) begin
				act[i] = nn_out_pkg::fix_t'(rand_below(HALF));            // Low half
			end else begin
				act[i] = nn_out_pkg::fix_t'(HALF + rand_below(HALF + 1)); // High half
			end
			sp[i] = nn_out_pkg::fix_t'(rand_below(ONE / 4 + 1)); // Sigmoid prime peaks at 1/4
			y[i]  = (rand_below(2) == 1);
		end
		// Threshold corners
		if (k == 1 && s % 4 == 1) begin
			act[0] = nn_out_pkg::fix_t'(HALF - 1);
			act[1] = nn_out_pkg::fix_t'(HALF);
		end
		if (k == 2 && s % 4 == 3) begin
			act[0] = nn_out_pkg::fix_t'(ONE);
		end
		// Ideal 1 issued two samples ahead meets act 0 under cross-entropy
		if (k == 0 && s >= N_QUAD - 2) begin
			y[0] = 1'b1;
		end
		if (k == 0 && s >= N_QUAD) begin
			act[0] = '0;
		end
		cur_sample    = s;
		cycle_index_i = nn_out_pkg::cycle_idx_t'(k);
		cost_sel_i    = (s < N_QUAD) ? nn_out_pkg::COST_QUAD : nn_out_pkg::COST_XENT;
		act_l_i       = act;
		sp_l_i        = sp;
		y_i           = y;
	endtask

	// Comparison at mid cycle, inputs and outputs both settled
	always @(negedge clk) begin
		nn_out_pkg::fix_vec_t new_d;
		nn_out_pkg::bit_vec_t dec_exp;
		logic                 rd_bank_m;
		if (run_checks) begin
			// Registered outputs show the previous edge
			check_bit_vec("y_l_o", y_l_o, y_pipe[0]);
			check_fix_vec("delta_l_o", delta_l_o, delta_exp);
			if (cur_sample == 0) begin
				check_idle("during sample 0", cycle_index_i == 0); // y too right after reset
			end
			for (int i = 0; i < nn_out_pkg::Z; i++) begin
				dec_exp[i] = ref_decision(act_l_i[i]);
				new_d[i]   = ref_delta(act_l_i[i], sp_l_i[i], y_pipe[0][i], cost_sel_i);
			end
			check_bit_vec("a_out_o", a_out_o, dec_exp); // Combinational, same cycle
			// Step the models over the coming edge
			rd_bank_m = !wr_bank_m;
			if (cycle_index_i < nn_out_pkg::GROUPS) begin
				delta_exp = bank_m[rd_bank_m][cycle_index_i];   // Previous sample
				bank_m[wr_bank_m][cycle_index_i] = new_d;       // Current sample
			end
			if (cycle_index_i == nn_out_pkg::CPC - 1) begin
				wr_bank_m = rd_bank_m; // Banks swap roles
			end
			y_pipe.push_back(y_i);
			void'(y_pipe.pop_front());
		end
	end

	// Timeout guard
	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < MAX_CYCLES) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("Timeout, the run did not end within %0d cycles", MAX_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		seed          = 91597;
		value_errs    = 0;
		idle_errs     = 0;
		cur_sample    = 0;
		run_checks    = 1'b0;
		arst_n_i      = 1'b0;
		cycle_index_i = '0;
		cost_sel_i    = nn_out_pkg::COST_QUAD;
		act_l_i       = '0;
		sp_l_i        = '0;
		y_i           = '0;
		wr_bank_m     = 1'b0;
		delta_exp     = '0;
		for (int d = 0; d < nn_out_pkg::Y_DELAY; d++) begin
			y_pipe.push_back('0); // Delay line starts cleared
		end
		for (int b = 0; b < 2; b++) begin
			for (int g = 0; g < nn_out_pkg::GROUPS; g++) begin
				bank_m[b][g] = '0;
			end
		end

		repeat (RST_CYCLES) @(posedge clk);
		#(STIM_DLY);
		arst_n_i = 1'b1;
		drive_group(0, 0); // First group right at release
		run_checks = 1'b1;

		// Last sample only flushes the deltas of sample N_SAMPLES-1
		for (int s = 0; s <= N_SAMPLES; s++) begin
			for (int k = 0; k < nn_out_pkg::CPC; k++) begin
				if (s != 0 || k != 0) begin
					@(posedge clk);
					#(STIM_DLY);
					drive_group(s, k);
				end
			end
		end
		@(posedge clk);
		#(STIM_DLY);
		run_checks = 1'b0;

		$display("Errors: %0d value, %0d idle", value_errs, idle_errs);
		if (value_errs == 0 && idle_errs == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- src/delta_mem_banks.sv
// Ping-pong delta banks with a registered read port toward the previous layer
`timescale 1ns/1ps
`default_nettype none

module delta_mem_banks (
	input  wire logic                 clk,
	input  wire logic                 arst_n_i,
	delta_mem_if.mem                  mem_i,
	output nn_out_pkg::fix_vec_t      delta_o // Previous sample's deltas
);

	localparam int NBANK = 2;
	localparam int DEPTH = nn_out_pkg::GROUPS;

	// Two banks, each holding one sample worth of deltas
	nn_out_pkg::fix_vec_t bank_q [NBANK][DEPTH];

	logic                 rd_bank;  // Bank holding the finished sample
	nn_out_pkg::fix_vec_t rd_word;  // Raw read before the output register
	nn_out_pkg::fix_vec_t delta_q;

	// Reader always looks at the bank the writer is not using
	assign rd_bank = ~mem_i.wr_bank;

	// Asynchronous read from the idle bank
	assign rd_word = bank_q[rd_bank][mem_i.rd_addr];

	// Write port
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int b = 0; b < NBANK; b++) begin
				for (int g = 0; g < DEPTH; g++) begin
					bank_q[b][g] <= '0; // Sample 0 reads back zeros
				end
			end
		end else if (mem_i.wr_en) begin
			bank_q[mem_i.wr_bank][mem_i.wr_addr] <= mem_i.wr_data;
		end
	end

	/*
	 * Read register
	 * One cycle after index k the previous layer sees group k.
	 * Between data cycles the last group stays on the output.
	 */
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			delta_q <= '0;
		end else if (mem_i.rd_en) begin
			delta_q <= rd_word;
		end
	end

	assign delta_o = delta_q;

endmodule

`default_nettype wire

//--- src/delta_mem_ctrl.sv
// Delta memory controller that decodes the cycle index and owns the ping-pong bank pointer
`timescale 1ns/1ps
`default_nettype none

module delta_mem_ctrl (
	input  wire logic                   clk,
	input  wire logic                   arst_n_i,
	input  wire nn_out_pkg::cycle_idx_t cycle_index_i, // 0 to CPC-1, wraps
	input  wire nn_out_pkg::fix_vec_t   delta_i,       // Fresh deltas from cost unit
	delta_mem_if.ctrl                   mem_o
);

	// Index of the last data cycle and of the last clock of a sample
	localparam nn_out_pkg::cycle_idx_t GRP_END =
		nn_out_pkg::cycle_idx_t'(nn_out_pkg::GROUPS);
	localparam nn_out_pkg::cycle_idx_t LAST_IDX =
		nn_out_pkg::cycle_idx_t'(nn_out_pkg::CPC - 1);

	logic                  data_phase;  // Index names a group
	logic                  last_cycle;  // Final clock of the sample
	nn_out_pkg::grp_addr_t grp_addr;    // Group number of this cycle
	logic                  wr_bank_q;   // Bank taking current sample

	/*
	 * Per-sample schedule
	 *   index 0..GROUPS-1  group k written to wr_bank, group k of
	 *                      previous sample read from the other bank
	 *   index GROUPS       idle, read port holds
	 *   index CPC-1        idle, pointer flips at the edge
	 */
	assign data_phase = (cycle_index_i < GRP_END);
	assign last_cycle = (cycle_index_i == LAST_IDX);

	// Groups map one to one onto cycle indices
	assign grp_addr = nn_out_pkg::grp_addr_t'(cycle_index_i);

	// Bank pointer
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_bank_q <= 1'b0;
		end else if (last_cycle) begin
			wr_bank_q <= ~wr_bank_q; // Swap roles for next sample
		end
	end

	// Write port, same cycle as the delta is formed
	assign mem_o.wr_en   = data_phase;
	assign mem_o.wr_addr = grp_addr;
	assign mem_o.wr_data = delta_i;

	// Read port runs in lockstep with the write port
	assign mem_o.rd_en   = data_phase;
	assign mem_o.rd_addr = grp_addr;

	assign mem_o.wr_bank = wr_bank_q;

endmodule

`default_nettype wire

//--- src/delta_mem_if.sv
// Delta memory interface carrying write and read controls from controller to banks
`timescale 1ns/1ps
`default_nettype none

interface delta_mem_if;

	// Write side, current sample
	logic                 wr_en;   // Write this cycle
	nn_out_pkg::grp_addr_t wr_addr; // Group being written
	nn_out_pkg::fix_vec_t  wr_data; // Z deltas of that group

	// Read side, previous sample
	logic                 rd_en;   // Read this cycle
	nn_out_pkg::grp_addr_t rd_addr; // Group going back to previous layer

	// Ping-pong pointer
	// Read bank is always the other one
	logic wr_bank;

	modport ctrl (
		output wr_en,
		output wr_addr,
		output wr_data,
		output rd_en,
		output rd_addr,
		output wr_bank
	);

	modport mem (
		input wr_en,
		input wr_addr,
		input wr_data,
		input rd_en,
		input rd_addr,
		input wr_bank
	);

endinterface

`default_nettype wire

//--- src/ideal_out_delay.sv
// Ideal output delay line matching the network latency
`timescale 1ns/1ps
`default_nettype none

module ideal_out_delay (
	input  wire logic                 clk,
	input  wire logic                 arst_n_i,
	input  wire nn_out_pkg::bit_vec_t y_i, // Ideal outputs at network entry
	output nn_out_pkg::bit_vec_t      y_o  // Same bits at the output layer
);

	localparam int DEPTH = nn_out_pkg::Y_DELAY;

	// Stage 0 takes y_i, last stage drives y_o
	nn_out_pkg::bit_vec_t stage_q [DEPTH];

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int s = 0; s < DEPTH; s++) begin
				stage_q[s] <= '0;
			end
		end else begin
			stage_q[0] <= y_i;
			for (int s = 1; s < DEPTH; s++) begin
				stage_q[s] <= stage_q[s-1]; // One sample period per CPC stages
			end
		end
	end

	// Lines up with actL of the same sample
	assign y_o = stage_q[DEPTH-1];

endmodule

`default_nettype wire

//--- src/nn_out_pkg.sv
// Output layer package with the fixed-point format, layer geometry and shared types
`default_nettype none

package nn_out_pkg;

	// Fixed-point format is sign + INT_BITS + FRAC_BITS
	localparam int WIDTH     = 16;
	localparam int INT_BITS  = 5;
	localparam int FRAC_BITS = 10;

	// Layer geometry
	localparam int P       = 8;           // Output neurons per sample
	localparam int Z       = 2;           // Neurons handled per clock
	localparam int GROUPS  = P / Z;       // Data cycles per sample, also delta bank depth
	localparam int CPC     = GROUPS + 2;  // Clocks per sample
	localparam int L       = 3;           // Layers in the network
	localparam int Y_DELAY = CPC * (L - 1); // Ideal outputs travel this far

	// Counter and address widths
	localparam int CIDX_W = $clog2(CPC);
	localparam int GADR_W = $clog2(GROUPS);

	// One fixed-point word
	typedef logic signed [WIDTH-1:0] fix_t;

	// Z words side by side, lane 0 in the low bits
	typedef fix_t [Z-1:0] fix_vec_t;

	// One bit per lane, for ideal outputs and decisions
	typedef logic [Z-1:0] bit_vec_t;

	typedef logic [CIDX_W-1:0] cycle_idx_t; // Counts 0 to CPC-1
	typedef logic [GADR_W-1:0] grp_addr_t;  // Delta bank address

	// Fixed-point constants
	localparam fix_t ONE_FIX  = fix_t'(1 << FRAC_BITS);       // 1.0
	localparam fix_t HALF_FIX = fix_t'(1 << (FRAC_BITS - 1)); // 0.5

	// Cost kind, quasi-static level
	typedef enum logic {
		COST_QUAD = 1'b0, // Quadratic cost, delta = (a - y) * sp
		COST_XENT = 1'b1  // Cross-entropy cost, delta = a - y
	} cost_e;

endpackage

`default_nettype wire

//--- src/output_cost_unit.sv
// Output cost unit forming the cost term, the output delta and thresholded decisions
`timescale 1ns/1ps
`default_nettype none

module output_cost_unit (
	input  wire nn_out_pkg::cost_e    cost_sel_i, // Quadratic or cross-entropy
	input  wire nn_out_pkg::fix_vec_t act_i,      // Output layer activations
	input  wire nn_out_pkg::fix_vec_t sp_i,       // Sigmoid prime of the same neurons
	input  wire nn_out_pkg::bit_vec_t y_i,        // Ideal outputs, already delayed
	output nn_out_pkg::fix_vec_t      delta_o,    // Delta per lane
	output nn_out_pkg::bit_vec_t      decision_o  // 1-bit output per lane
);

	localparam int W  = nn_out_pkg::WIDTH;
	localparam int FB = nn_out_pkg::FRAC_BITS;

	// Per-lane intermediates
	nn_out_pkg::fix_t    y_fix     [nn_out_pkg::Z]; // Ideal bit as 1.0 or 0.0
	nn_out_pkg::fix_t    cost_term [nn_out_pkg::Z]; // a - y
	logic signed [2*W-1:0] prod_full [nn_out_pkg::Z]; // Full width product
	logic signed [2*W-1:0] prod_shft [nn_out_pkg::Z]; // Realigned to the binary point
	nn_out_pkg::fix_t    prod_fix  [nn_out_pkg::Z];

	always_comb begin
		for (int i = 0; i < nn_out_pkg::Z; i++) begin
			// Ideal outputs are single bits from the environment
			y_fix[i] = y_i[i] ? nn_out_pkg::ONE_FIX : '0;

			// Cost term wraps at WIDTH bits
			cost_term[i] = act_i[i] - y_fix[i];

			// Q5.10 times Q5.10 gives 20 fraction bits
			prod_full[i] = cost_term[i] * sp_i[i];
			prod_shft[i] = prod_full[i] >>> FB; // Arithmetic, keeps sign
			prod_fix[i]  = prod_shft[i][W-1:0]; // Truncate to the word

			// Delta choice follows the cost level
			if (cost_sel_i == nn_out_pkg::COST_QUAD) begin
				delta_o[i] = prod_fix[i];
			end else begin
				delta_o[i] = cost_term[i]; // sp cancels under cross-entropy
			end

			// Sigmoid threshold at one half, signed compare
			decision_o[i] = (act_i[i] >= nn_out_pkg::HALF_FIX);
		end
	end

endmodule

`default_nettype wire

//--- src/output_layer_top.sv
// Output layer top joining the cost unit, delta memory and ideal output delay
`timescale 1ns/1ps
`default_nettype none

module output_layer_top (
	input  wire logic                   clk,
	input  wire logic                   arst_n_i,
	input  wire nn_out_pkg::cycle_idx_t cycle_index_i, // Index inside the sample
	input  wire nn_out_pkg::cost_e      cost_sel_i,    // Changes only at sample boundaries
	input  wire nn_out_pkg::fix_vec_t   act_l_i,       // From last hidden layer
	input  wire nn_out_pkg::fix_vec_t   sp_l_i,        // From last hidden layer
	input  wire nn_out_pkg::bit_vec_t   y_i,           // Ideal outputs at network entry
	output nn_out_pkg::fix_vec_t        delta_l_o,     // Back to last hidden layer
	output nn_out_pkg::bit_vec_t        y_l_o,         // Ideal outputs at network exit
	output nn_out_pkg::bit_vec_t        a_out_o        // Network decisions
);

	nn_out_pkg::fix_vec_t delta; // Fresh deltas, into the write port

	// Controller to banks
	delta_mem_if dmem_if ();

	// Ideal outputs follow the samples through all earlier layers
	ideal_out_delay u_ideal_delay (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.y_i      (y_i),
		.y_o      (y_l_o)
	);

	// Cost and decisions, no latency
	output_cost_unit u_cost (
		.cost_sel_i (cost_sel_i),
		.act_i      (act_l_i),
		.sp_i       (sp_l_i),
		.y_i        (y_l_o),    // Delayed ideals meet their activations here
		.delta_o    (delta),
		.decision_o (a_out_o)
	);

	// Strobes, addresses and bank pointer
	delta_mem_ctrl u_dmem_ctrl (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.cycle_index_i (cycle_index_i),
		.delta_i       (delta),
		.mem_o         (dmem_if)
	);

	// Current sample in, previous sample out
	delta_mem_banks u_dmem_banks (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.mem_i    (dmem_if),
		.delta_o  (delta_l_o)
	);

endmodule

`default_nettype wire
